// ==== rob_pkg.sv ====
/* shared types for the rename and reorder buffer slice
   imported by the RTL modules and by the testbench */
`default_nettype none

package rob_pkg;

    // architectural register file size
    localparam int ARCH_REGS = 32;

    // architectural register index
    typedef logic [4:0] arch_reg_t;

    // instruction address
    typedef logic [31:0] pc_t;

    // instruction kind carried through dispatch and retirement
    // halts take no tag and enter the reorder buffer already complete
    typedef enum logic {
        KIND_REG_WRITE = 1'b0,
        KIND_HALT      = 1'b1
    } inst_kind_e;

endpackage

`default_nettype wire

// ==== free_list.sv ====
/* circular queue of free physical tags, hands out up to WIDTH per cycle
   and takes back the t_old tags of retiring register writes */
`timescale 1ns/1ps
`default_nettype none

module free_list import rob_pkg::*; #(
    parameter int WIDTH = 2,
    parameter int PHYS_REGS = 48,
    localparam int TAG_W = $clog2(PHYS_REGS),
    localparam int CNT_W = $clog2(WIDTH + 1),
    localparam int FREE_W = $clog2(PHYS_REGS - ARCH_REGS + 1)
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [CNT_W-1:0]              alloc_count,
    output logic [WIDTH-1:0][TAG_W-1:0]   alloc_t,
    output logic [FREE_W-1:0]             free_count,
    input  logic [WIDTH-1:0]              retire_valid,
    input  inst_kind_e [WIDTH-1:0]        retire_kind,
    input  logic [WIDTH-1:0][TAG_W-1:0]   retire_t_old
);
    localparam int CAP = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = (CAP > 1) ? $clog2(CAP) : 1;

    logic [TAG_W-1:0] tags [CAP];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [FREE_W-1:0] count;

    // per slot write position for returning tags
    logic [WIDTH-1:0][PTR_W-1:0] ret_idx;
    logic [WIDTH-1:0] ret_take;
    logic [CNT_W-1:0] ret_n;

    // queue positions wrap at capacity, which need not be a power of two
    function automatic logic [PTR_W-1:0] wrap(input int v);
        return PTR_W'(v % CAP);
    endfunction

    assign free_count = count;

    always_comb begin
        int n;
        n = 0;
        for (int j = 0; j < WIDTH; j++) begin
            // slot j sees the tag j places behind head
            alloc_t[j] = tags[wrap(int'(head) + j)];
            // returned tags pack densely behind tail in slot order
            ret_take[j] = retire_valid[j] && (retire_kind[j] == KIND_REG_WRITE);
            ret_idx[j] = wrap(int'(tail) + n);
            if (ret_take[j]) begin
                n++;
            end
        end
        ret_n = CNT_W'(n);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= FREE_W'(CAP);
            // every tag above the identity mapping starts out free
            for (int i = 0; i < CAP; i++) begin
                tags[i] <= TAG_W'(ARCH_REGS + i);
            end
        end else begin
            head <= wrap(int'(head) + int'(alloc_count));
            tail <= wrap(int'(tail) + int'(ret_n));
            // returned tags are not visible until the next cycle
            count <= count - alloc_count + ret_n;
            for (int j = 0; j < WIDTH; j++) begin
                if (ret_take[j]) begin
                    tags[ret_idx[j]] <= retire_t_old[j];
                end
            end
        end
    end

    // rename must never take more tags than the queue holds
    a_alloc_bound: assert property (@(posedge clock) disable iff (reset)
        alloc_count <= free_count);

    // a tag comes back only after being handed out, so the queue cannot overfill
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= CAP);

endmodule

`default_nettype wire

// ==== rename_map.sv ====
/* speculative and architectural map tables with the dispatch accept limit
   renames up to WIDTH slots per cycle and resolves same-group dependencies */
`timescale 1ns/1ps
`default_nettype none

module rename_map import rob_pkg::*; #(
    parameter int WIDTH = 2,
    parameter int PHYS_REGS = 48,
    localparam int TAG_W = $clog2(PHYS_REGS),
    localparam int CNT_W = $clog2(WIDTH + 1),
    localparam int FREE_W = $clog2(PHYS_REGS - ARCH_REGS + 1)
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [WIDTH-1:0]              in_valid,
    input  inst_kind_e [WIDTH-1:0]        in_kind,
    input  arch_reg_t [WIDTH-1:0]         in_dest,
    output logic [WIDTH-1:0]              in_ready,
    output logic [WIDTH-1:0][TAG_W-1:0]   in_t,
    output logic [WIDTH-1:0][TAG_W-1:0]   in_t_old,
    output logic [CNT_W-1:0]              accept_count,
    output logic [CNT_W-1:0]              alloc_count,
    input  logic [WIDTH-1:0][TAG_W-1:0]   alloc_t,
    input  logic [FREE_W-1:0]             free_count,
    input  logic [CNT_W-1:0]              open_count,
    input  logic                          halted,
    input  logic [WIDTH-1:0]              retire_valid,
    input  inst_kind_e [WIDTH-1:0]        retire_kind,
    input  arch_reg_t [WIDTH-1:0]         retire_dest,
    input  logic [WIDTH-1:0][TAG_W-1:0]   retire_t
);
    logic [TAG_W-1:0] spec_map [ARCH_REGS];
    // committed mappings, kept for a recovery path outside this slice
    logic [TAG_W-1:0] arch_map [ARCH_REGS];

    // slots taken this cycle, and the subset that renames a destination
    logic [WIDTH-1:0] take;
    logic [WIDTH-1:0] writes;

    always_comb begin
        int lim;
        int n;
        int acc;
        // conservative limit, every slot is assumed to need a tag
        lim = WIDTH;
        if (int'(open_count) < lim) begin
            lim = int'(open_count);
        end
        if (int'(free_count) < lim) begin
            lim = int'(free_count);
        end
        if (halted) begin
            lim = 0;
        end
        n = 0;
        acc = 0;
        for (int j = 0; j < WIDTH; j++) begin
            in_ready[j] = (j < lim);
            take[j] = in_valid[j] && in_ready[j];
            writes[j] = take[j] && (in_kind[j] == KIND_REG_WRITE);
            in_t[j] = '0;
            in_t_old[j] = '0;
            if (writes[j]) begin
                // tags go out in slot order among the writing slots
                in_t[j] = alloc_t[n];
                in_t_old[j] = spec_map[in_dest[j]];
                // the youngest older slot with the same dest overrides the table
                for (int i = 0; i < j; i++) begin
                    if (writes[i] && (in_dest[i] == in_dest[j])) begin
                        in_t_old[j] = in_t[i];
                    end
                end
                n++;
            end
            if (take[j]) begin
                acc++;
            end
        end
        // number of slots actually written into the reorder buffer
        accept_count = CNT_W'(acc);
        alloc_count = CNT_W'(n);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= TAG_W'(i);
                arch_map[i] <= TAG_W'(i);
            end
        end else begin
            // later slots overwrite earlier ones, youngest wins
            for (int j = 0; j < WIDTH; j++) begin
                if (writes[j]) begin
                    spec_map[in_dest[j]] <= in_t[j];
                end
            end
            for (int j = 0; j < WIDTH; j++) begin
                if (retire_valid[j] && (retire_kind[j] == KIND_REG_WRITE)) begin
                    arch_map[retire_dest[j]] <= retire_t[j];
                end
            end
        end
    end

    // valid slots form a prefix starting at slot 0
    a_valid_prefix: assert property (@(posedge clock) disable iff (reset)
        (in_valid & (in_valid + 1'b1)) == '0);

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
/* N-way circular reorder buffer, retires completed entries in order
   from head and writes newly dispatched entries at tail */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import rob_pkg::*; #(
    parameter int WIDTH = 2,
    parameter int ROB_DEPTH = 16,
    parameter int PHYS_REGS = 48,
    localparam int TAG_W = $clog2(PHYS_REGS),
    localparam int CNT_W = $clog2(WIDTH + 1)
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [CNT_W-1:0]              accept_count,
    input  inst_kind_e [WIDTH-1:0]        in_kind,
    input  arch_reg_t [WIDTH-1:0]         in_dest,
    input  pc_t [WIDTH-1:0]               in_pc,
    input  logic [WIDTH-1:0][TAG_W-1:0]   in_t,
    input  logic [WIDTH-1:0][TAG_W-1:0]   in_t_old,
    input  logic [WIDTH-1:0]              complete_valid,
    input  logic [WIDTH-1:0][TAG_W-1:0]   complete_t,
    output logic [CNT_W-1:0]              open_count,
    output logic                          halted,
    output logic [WIDTH-1:0]              retire_valid,
    output arch_reg_t [WIDTH-1:0]         retire_dest,
    output logic [WIDTH-1:0][TAG_W-1:0]   retire_t,
    output logic [WIDTH-1:0][TAG_W-1:0]   retire_t_old,
    output pc_t [WIDTH-1:0]               retire_pc,
    output inst_kind_e [WIDTH-1:0]        retire_kind
);
    localparam int PTR_W = $clog2(ROB_DEPTH);

    // entry state, one packed array per field
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_complete;
    inst_kind_e [ROB_DEPTH-1:0] ent_kind;
    arch_reg_t [ROB_DEPTH-1:0] ent_dest;
    pc_t [ROB_DEPTH-1:0] ent_pc;
    logic [ROB_DEPTH-1:0][TAG_W-1:0] ent_t;
    logic [ROB_DEPTH-1:0][TAG_W-1:0] ent_t_old;

    // pointers wrap for free since depth is a power of two
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0] count;
    logic [CNT_W-1:0] retire_n;

    always_comb begin
        logic stop;
        logic [PTR_W-1:0] idx;
        int n;
        int space;
        stop = 1'b0;
        n = 0;
        for (int i = 0; i < WIDTH; i++) begin
            idx = head + PTR_W'(i);
            retire_dest[i] = ent_dest[idx];
            retire_t[i] = ent_t[idx];
            retire_t_old[i] = ent_t_old[idx];
            retire_pc[i] = ent_pc[idx];
            retire_kind[i] = ent_kind[idx];
            retire_valid[i] = 1'b0;
            // scan stops at the first entry not ready to leave
            if (!stop && ent_valid[idx] && ent_complete[idx]) begin
                retire_valid[i] = 1'b1;
                n++;
            end else begin
                stop = 1'b1;
            end
        end
        retire_n = CNT_W'(n);
        // slots freed by this cycle's retirement count as open
        space = ROB_DEPTH - int'(count) + n;
        open_count = (space > WIDTH) ? CNT_W'(WIDTH) : CNT_W'(space);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            ent_valid <= '0;
            ent_complete <= '0;
            halted <= 1'b0;
        end else begin
            head <= head + PTR_W'(retire_n);
            tail <= tail + PTR_W'(accept_count);
            count <= count - retire_n + accept_count;
            for (int i = 0; i < WIDTH; i++) begin
                if (retire_valid[i]) begin
                    ent_valid[head + PTR_W'(i)] <= 1'b0;
                    // dispatch stops for good once a halt commits
                    if (retire_kind[i] == KIND_HALT) begin
                        halted <= 1'b1;
                    end
                end
            end
            // broadcast compare of every completion port against every entry
            for (int k = 0; k < ROB_DEPTH; k++) begin
                for (int p = 0; p < WIDTH; p++) begin
                    if (complete_valid[p] && ent_valid[k] && (ent_t[k] == complete_t[p])) begin
                        ent_complete[k] <= 1'b1;
                    end
                end
            end
            // new entries last, so a slot freed this cycle is reused cleanly
            for (int j = 0; j < WIDTH; j++) begin
                if (j < accept_count) begin
                    ent_valid[tail + PTR_W'(j)] <= 1'b1;
                    ent_complete[tail + PTR_W'(j)] <= (in_kind[j] == KIND_HALT);
                end
            end
        end
    end

    // payload fields, qualified by ent_valid
    always_ff @(posedge clock) begin
        for (int j = 0; j < WIDTH; j++) begin
            if (j < accept_count) begin
                ent_kind[tail + PTR_W'(j)] <= in_kind[j];
                ent_dest[tail + PTR_W'(j)] <= in_dest[j];
                ent_pc[tail + PTR_W'(j)] <= in_pc[j];
                ent_t[tail + PTR_W'(j)] <= in_t[j];
                ent_t_old[tail + PTR_W'(j)] <= in_t_old[j];
            end
        end
    end

    // occupancy stays within the buffer across dispatch and retirement
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= ROB_DEPTH);

    // the rename stage honours the open slot count it is given
    a_accept_bound: assert property (@(posedge clock) disable iff (reset)
        accept_count <= open_count);

endmodule

`default_nettype wire

// ==== rob_core_top.sv ====
/* rename and reorder buffer slice, connects the rename map, free list
   and reorder buffer and sets their parameters */
`timescale 1ns/1ps
`default_nettype none

module rob_core_top import rob_pkg::*; #(
    parameter int WIDTH = 2,
    parameter int ROB_DEPTH = 16,
    parameter int PHYS_REGS = 48,
    localparam int TAG_W = $clog2(PHYS_REGS)
) (
    input  logic                          clock,
    input  logic                          reset,
    // dispatch
    input  logic [WIDTH-1:0]              in_valid,
    input  inst_kind_e [WIDTH-1:0]        in_kind,
    input  arch_reg_t [WIDTH-1:0]         in_dest,
    input  pc_t [WIDTH-1:0]               in_pc,
    output logic [WIDTH-1:0]              in_ready,
    output logic [WIDTH-1:0][TAG_W-1:0]   in_t,
    output logic [WIDTH-1:0][TAG_W-1:0]   in_t_old,
    // completion from the execution units
    input  logic [WIDTH-1:0]              complete_valid,
    input  logic [WIDTH-1:0][TAG_W-1:0]   complete_t,
    // retirement
    output logic [WIDTH-1:0]              retire_valid,
    output arch_reg_t [WIDTH-1:0]         retire_dest,
    output logic [WIDTH-1:0][TAG_W-1:0]   retire_t,
    output logic [WIDTH-1:0][TAG_W-1:0]   retire_t_old,
    output pc_t [WIDTH-1:0]               retire_pc,
    output inst_kind_e [WIDTH-1:0]        retire_kind,
    output logic                          halted
);
    localparam int CNT_W = $clog2(WIDTH + 1);
    localparam int FREE_W = $clog2(PHYS_REGS - ARCH_REGS + 1);

    logic [CNT_W-1:0] accept_count;
    logic [CNT_W-1:0] alloc_count;
    logic [CNT_W-1:0] open_count;
    logic [FREE_W-1:0] free_count;
    logic [WIDTH-1:0][TAG_W-1:0] alloc_t;

    rename_map #(.WIDTH(WIDTH), .PHYS_REGS(PHYS_REGS)) rename_map_i (
        .clock, .reset,
        .in_valid, .in_kind, .in_dest,
        .in_ready, .in_t, .in_t_old,
        .accept_count, .alloc_count,
        .alloc_t, .free_count,
        .open_count, .halted,
        .retire_valid, .retire_kind, .retire_dest, .retire_t
    );

    free_list #(.WIDTH(WIDTH), .PHYS_REGS(PHYS_REGS)) free_list_i (
        .clock, .reset,
        .alloc_count, .alloc_t, .free_count,
        .retire_valid, .retire_kind, .retire_t_old
    );

    reorder_buffer #(.WIDTH(WIDTH), .ROB_DEPTH(ROB_DEPTH), .PHYS_REGS(PHYS_REGS)) rob_i (
        .clock, .reset,
        .accept_count,
        .in_kind, .in_dest, .in_pc, .in_t, .in_t_old,
        .complete_valid, .complete_t,
        .open_count, .halted,
        .retire_valid, .retire_dest, .retire_t, .retire_t_old, .retire_pc, .retire_kind
    );

endmodule

`default_nettype wire

// ==== tb_rob_core.sv ====
/* random-stimulus testbench for rob_core_top that checks rename, retirement,
   tag recycling, back-pressure and halt against a reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_rob_core import rob_pkg::*; ();

    localparam int WIDTH = 2;
    localparam int ROB_DEPTH = 16;
    localparam int PHYS_REGS = 48;
    localparam int TAG_W = $clog2(PHYS_REGS);
    localparam int CLK_PERIOD = 8;
    localparam int RANDOM_CYCLES = 400;
    localparam int FILL_CYCLES = ROB_DEPTH / WIDTH + 4;
    localparam int DRAIN_LIMIT = ROB_DEPTH + 8;
    localparam int HALT_HOLD = 6;
    // cycles for reset, random run, fill, halt and three drains
    localparam int TOTAL_CYCLES = 3 + RANDOM_CYCLES + FILL_CYCLES + 1 + HALT_HOLD
        + 3 * DRAIN_LIMIT;

    // dispatch modes for the stimulus
    localparam int DISP_NONE = 0;
    localparam int DISP_RANDOM = 1;
    localparam int DISP_FULL = 2;
    localparam int DISP_HALT = 3;

    logic clock;
    logic reset;
    logic [WIDTH-1:0] in_valid;
    inst_kind_e [WIDTH-1:0] in_kind;
    arch_reg_t [WIDTH-1:0] in_dest;
    pc_t [WIDTH-1:0] in_pc;
    logic [WIDTH-1:0] in_ready;
    logic [WIDTH-1:0][TAG_W-1:0] in_t;
    logic [WIDTH-1:0][TAG_W-1:0] in_t_old;
    logic [WIDTH-1:0] complete_valid;
    logic [WIDTH-1:0][TAG_W-1:0] complete_t;
    logic [WIDTH-1:0] retire_valid;
    arch_reg_t [WIDTH-1:0] retire_dest;
    logic [WIDTH-1:0][TAG_W-1:0] retire_t;
    logic [WIDTH-1:0][TAG_W-1:0] retire_t_old;
    pc_t [WIDTH-1:0] retire_pc;
    inst_kind_e [WIDTH-1:0] retire_kind;
    logic halted;

    // reference model state
    logic [31:0] rng_state;
    int spec_map [ARCH_REGS];
    int free_q [$];
    int outstanding [$];
    // in-flight instructions oldest first with one queue per field
    int fl_kind [$];
    int fl_dest [$];
    int fl_t [$];
    int fl_t_old [$];
    int fl_pc [$];
    bit fl_done [$];
    bit model_halted;
    int halts_retired;
    int retired_total;
    int dispatched_total;
    int pc_base;
    int errors;
    int checks;
    int tests_run;

    rob_core_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic int unsigned next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "fail");
    endtask

    // drives stimulus for the next edge and completes only outstanding tags
    task automatic drive_inputs(input int mode, input int complete_pct);
        int nv;
        int idx;
        int dest;
        int pool [$];
        case (mode)
            DISP_RANDOM: nv = next_rand() % (WIDTH + 1);
            DISP_FULL, DISP_HALT: nv = WIDTH;
            default: nv = 0;
        endcase
        dest = 0;
        for (int j = 0; j < WIDTH; j++) begin
            // repeat the previous dest now and then to hit same-group overrides
            if (j == 0 || (next_rand() % 3) != 0) begin
                dest = next_rand() % ARCH_REGS;
            end
            in_valid[j] <= (j < nv);
            in_kind[j] <= (mode == DISP_HALT && j == WIDTH - 1) ? KIND_HALT : KIND_REG_WRITE;
            in_dest[j] <= arch_reg_t'(dest);
            in_pc[j] <= pc_t'(pc_base + 4 * j);
        end
        pc_base = pc_base + 4 * WIDTH;
        pool = outstanding;
        for (int p = 0; p < WIDTH; p++) begin
            if (pool.size() > 0 && (next_rand() % 100) < complete_pct) begin
                idx = next_rand() % pool.size();
                complete_valid[p] <= 1'b1;
                complete_t[p] <= TAG_W'(pool[idx]);
                pool.delete(idx);
            end else begin
                complete_valid[p] <= 1'b0;
                complete_t[p] <= TAG_W'(next_rand() % PHYS_REGS);
            end
        end
    endtask

    // checks outputs mid-cycle and then advances the model across the coming edge
    task automatic model_step();
        int n_ret;
        int open_n;
        int ready_n;
        int t_new;
        int t_prev;
        int found;
        int idx;
        int returned [$];
        bit halt_seen;
        n_ret = 0;
        halt_seen = 1'b0;
        while (n_ret < WIDTH && n_ret < fl_t.size() && fl_done[n_ret]) begin
            n_ret++;
        end
        for (int j = 0; j < WIDTH; j++) begin
            check_value("retire_valid", retire_valid[j], j < n_ret);
            // tallies of what the DUT actually retired
            if (retire_valid[j]) begin
                retired_total++;
                if (retire_kind[j] == KIND_HALT) begin
                    halts_retired++;
                end
            end
        end
        for (int j = 0; j < n_ret; j++) begin
            check_value("retire_kind", retire_kind[j], fl_kind[j]);
            check_value("retire_pc", retire_pc[j], fl_pc[j]);
            check_value("retire_dest", retire_dest[j], fl_dest[j]);
            if (fl_kind[j] == KIND_REG_WRITE) begin
                check_value("retire_t", retire_t[j], fl_t[j]);
                check_value("retire_t_old", retire_t_old[j], fl_t_old[j]);
            end
        end
        // retiring entries count as open but returning tags do not count as free
        open_n = ROB_DEPTH - fl_t.size() + n_ret;
        ready_n = WIDTH;
        if (open_n < ready_n) ready_n = open_n;
        if (free_q.size() < ready_n) ready_n = free_q.size();
        if (model_halted) ready_n = 0;
        check_value("in_ready", in_ready, (1 << ready_n) - 1);
        check_value("halted", halted, model_halted);
        for (int j = 0; j < n_ret; j++) begin
            if (fl_kind[0] == KIND_REG_WRITE) begin
                returned.push_back(fl_t_old[0]);
            end else begin
                halt_seen = 1'b1;
            end
            void'(fl_kind.pop_front());
            void'(fl_dest.pop_front());
            void'(fl_t.pop_front());
            void'(fl_t_old.pop_front());
            void'(fl_pc.pop_front());
            void'(fl_done.pop_front());
        end
        for (int j = 0; j < WIDTH; j++) begin
            if (in_valid[j] && j < ready_n) begin
                dispatched_total++;
                fl_kind.push_back(int'(in_kind[j]));
                fl_dest.push_back(int'(in_dest[j]));
                fl_pc.push_back(int'(in_pc[j]));
                if (in_kind[j] == KIND_REG_WRITE) begin
                    t_new = free_q.pop_front();
                    // sequential map updates make the youngest earlier slot win
                    t_prev = spec_map[in_dest[j]];
                    check_value("in_t", in_t[j], t_new);
                    check_value("in_t_old", in_t_old[j], t_prev);
                    found = 0;
                    foreach (outstanding[i]) begin
                        if (outstanding[i] == int'(in_t[j])) found = 1;
                    end
                    check_value("in_t matches an outstanding tag", found, 0);
                    spec_map[in_dest[j]] = t_new;
                    outstanding.push_back(t_new);
                    fl_t.push_back(t_new);
                    fl_t_old.push_back(t_prev);
                    fl_done.push_back(1'b0);
                end else begin
                    // halts enter already complete
                    fl_t.push_back(0);
                    fl_t_old.push_back(0);
                    fl_done.push_back(1'b1);
                end
            end
        end
        foreach (returned[i]) free_q.push_back(returned[i]);
        for (int p = 0; p < WIDTH; p++) begin
            if (complete_valid[p]) begin
                idx = -1;
                foreach (outstanding[i]) begin
                    if (outstanding[i] == int'(complete_t[p])) idx = i;
                end
                if (idx >= 0) outstanding.delete(idx);
                foreach (fl_t[i]) begin
                    if (fl_kind[i] == KIND_REG_WRITE && !fl_done[i]
                        && fl_t[i] == int'(complete_t[p])) begin
                        fl_done[i] = 1'b1;
                    end
                end
            end
        end
        if (halt_seen) begin
            model_halted = 1'b1;
        end
    endtask

    task automatic run_cycle(input int mode, input int complete_pct);
        @(posedge clock);
        drive_inputs(mode, complete_pct);
        @(negedge clock);
        model_step();
    endtask

    // complete everything and wait for the buffer to empty
    task automatic drain();
        while (fl_t.size() > 0) begin
            run_cycle(DISP_NONE, 100);
        end
    endtask

    initial begin
        int err_before;
        reset = 1'b1;
        in_valid = '0;
        in_dest = '0;
        in_pc = '0;
        complete_valid = '0;
        complete_t = '0;
        for (int j = 0; j < WIDTH; j++) begin
            in_kind[j] = KIND_REG_WRITE;
        end
        rng_state = 32'd58695;
        pc_base = 32'h1000;
        errors = 0;
        checks = 0;
        tests_run = 0;
        model_halted = 1'b0;
        halts_retired = 0;
        retired_total = 0;
        dispatched_total = 0;
        // identity map and a free list of the tags above it in order
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i] = i;
        end
        for (int t = ARCH_REGS; t < PHYS_REGS; t++) begin
            free_q.push_back(t);
        end

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        err_before = errors;
        check_value("retire_valid after reset", retire_valid, 0);
        check_value("halted after reset", halted, 0);
        check_value("in_ready after reset", in_ready, (1 << WIDTH) - 1);
        report_test("reset_state", err_before);

        err_before = errors;
        repeat (RANDOM_CYCLES) run_cycle(DISP_RANDOM, 60);
        drain();
        check_value("retirements in random run", retired_total, dispatched_total);
        report_test("random_rename_retire", err_before);

        // completions withheld so the buffer and free list run out together
        err_before = errors;
        repeat (FILL_CYCLES) run_cycle(DISP_FULL, 0);
        check_value("in_ready with full buffer", in_ready, 0);
        drain();
        report_test("back_pressure", err_before);

        err_before = errors;
        run_cycle(DISP_HALT, 0);
        while (!model_halted) begin
            run_cycle(DISP_NONE, 100);
        end
        repeat (HALT_HOLD) run_cycle(DISP_FULL, 100);
        check_value("halted after halt retired", halted, 1);
        check_value("in_ready after halt", in_ready, 0);
        check_value("halts retired", halts_retired, 1);
        report_test("halt", err_before);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // bound on the whole run at twice the expected length
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rob_pkg.sv
free_list.sv
rename_map.sv
reorder_buffer.sv
rob_core_top.sv
tb_rob_core.sv

// ==== Bender.yml ====
package:
  name: rob_core

dependencies: {}

sources:
  - rob_pkg.sv
  - free_list.sv
  - rename_map.sv
  - reorder_buffer.sv
  - rob_core_top.sv
  - target: test
    files:
      - tb_rob_core.sv
